/* src/wiscPkg.sv */
`default_nettype none

package wiscPkg;

	localparam int dataWidth = 16;
	localparam int regAddrWidth = 3;

	typedef enum logic [4:0] {
		opHalt   = 5'b00000,
		opNop    = 5'b00001,
		opSiic   = 5'b00010,
		opRti    = 5'b00011,
		opJ      = 5'b00100,
		opJr     = 5'b00101,
		opJal    = 5'b00110,
		opJalr   = 5'b00111,
		opAddi   = 5'b01000,
		opSubi   = 5'b01001,
		opXori   = 5'b01010,
		opAndni  = 5'b01011,
		opBeqz   = 5'b01100,
		opBnez   = 5'b01101,
		opBltz   = 5'b01110,
		opBgez   = 5'b01111,
		opSt     = 5'b10000,
		opLd     = 5'b10001,
		opSlbi   = 5'b10010,
		opStu    = 5'b10011,
		opRoli   = 5'b10100,
		opSlli   = 5'b10101,
		opRori   = 5'b10110,
		opSrli   = 5'b10111,
		opLbi    = 5'b11000,
		opBtr    = 5'b11001,
		opShiftR = 5'b11010, // ROL SLL ROR SRL by func
		opArithR = 5'b11011, // ADD SUB XOR ANDN by func
		opSeq    = 5'b11100,
		opSlt    = 5'b11101,
		opSle    = 5'b11110,
		opSco    = 5'b11111
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub, // b - a
		aluXor,
		aluAndn,
		aluRol,
		aluSll,
		aluRor,
		aluSrl,
		aluSeq,
		aluSlt,
		aluSle,
		aluSco,
		aluBtr,
		aluLbi,
		aluSlbi,
		aluPassB
	} aluOpT;

	typedef struct packed {
		logic regDst;
		logic aluSrc;
		logic branch;
		logic memRead;
		logic memWrite;
		logic jump;
		logic memToReg;
		logic regWrite;
		logic zeroExtend;
		logic i1Fmt;
		logic halt;
		logic err;
		aluOpT aluOp;
	} ctrlT;

endpackage

`default_nettype wire

/* src/ctrlIf.sv */
`default_nettype none
`timescale 1ns/1ns

interface ctrlIf;
	import wiscPkg::*;

	ctrlT ctrl; // Decoded levels for the current instruction

	modport dec (
		output ctrl
	);

	modport dp (
		input ctrl
	);

endinterface

`default_nettype wire

/* src/ctrlDecoder.sv */
`default_nettype none
`timescale 1ns/1ns

module ctrlDecoder (
	input wiscPkg::opcodeT opcode,
	input logic [1:0] func,
	ctrlIf.dec ctl
);
	import wiscPkg::*;

	aluOpT aluOp;

	always_comb
	begin
		case (opcode)
			opAddi, opSt, opLd, opStu: aluOp = aluAdd; // Address calc uses add
			opSubi: aluOp = aluSub;
			opXori: aluOp = aluXor;
			opAndni: aluOp = aluAndn;
			opRoli: aluOp = aluRol;
			opSlli: aluOp = aluSll;
			opRori: aluOp = aluRor;
			opSrli: aluOp = aluSrl;
			opBtr: aluOp = aluBtr;
			opShiftR:
			begin
				case (func)
					2'b00: aluOp = aluRol;
					2'b01: aluOp = aluSll;
					2'b10: aluOp = aluRor;
					default: aluOp = aluSrl;
				endcase
			end
			opArithR:
			begin
				case (func)
					2'b00: aluOp = aluAdd;
					2'b01: aluOp = aluSub;
					2'b10: aluOp = aluXor;
					default: aluOp = aluAndn;
				endcase
			end
			opSeq: aluOp = aluSeq;
			opSlt: aluOp = aluSlt;
			opSle: aluOp = aluSle;
			opSco: aluOp = aluSco;
			opLbi: aluOp = aluLbi;
			opSlbi: aluOp = aluSlbi;
			default: aluOp = aluPassB; // ALU result unused
		endcase
	end

	always_comb
	begin
		ctl.ctrl = '0;
		ctl.ctrl.aluOp = aluOp;
		case (opcode)
			opHalt:
				ctl.ctrl.halt = 1'b1;
			opNop, opSiic, opRti:
			begin
			end
			opAddi, opSubi, opRoli, opSlli, opRori, opSrli:
			begin
				ctl.ctrl.i1Fmt = 1'b1;
				ctl.ctrl.aluSrc = 1'b1;
				ctl.ctrl.regWrite = 1'b1;
			end
			opXori, opAndni:
			begin
				ctl.ctrl.i1Fmt = 1'b1;
				ctl.ctrl.aluSrc = 1'b1;
				ctl.ctrl.regWrite = 1'b1;
				ctl.ctrl.zeroExtend = 1'b1;
			end
			opSt:
			begin
				ctl.ctrl.i1Fmt = 1'b1;
				ctl.ctrl.aluSrc = 1'b1;
				ctl.ctrl.memWrite = 1'b1;
				ctl.ctrl.memRead = 1'b1;
				ctl.ctrl.memToReg = 1'b1;
			end
			opLd:
			begin
				ctl.ctrl.i1Fmt = 1'b1;
				ctl.ctrl.aluSrc = 1'b1;
				ctl.ctrl.memRead = 1'b1;
				ctl.ctrl.memToReg = 1'b1;
				ctl.ctrl.regWrite = 1'b1;
			end
			opStu:
			begin
				ctl.ctrl.i1Fmt = 1'b1;
				ctl.ctrl.aluSrc = 1'b1;
				ctl.ctrl.memWrite = 1'b1;
				ctl.ctrl.memRead = 1'b1;
				ctl.ctrl.regWrite = 1'b1; // Address back to rs
			end
			opBtr, opShiftR, opArithR, opSeq, opSlt, opSle, opSco:
			begin
				ctl.ctrl.regDst = 1'b1;
				ctl.ctrl.regWrite = 1'b1;
			end
			opBeqz, opBnez, opBltz, opBgez:
			begin
				ctl.ctrl.aluSrc = 1'b1;
				ctl.ctrl.branch = 1'b1;
			end
			opLbi:
			begin
				ctl.ctrl.aluSrc = 1'b1;
				ctl.ctrl.regWrite = 1'b1;
			end
			opSlbi:
			begin
				ctl.ctrl.aluSrc = 1'b1;
				ctl.ctrl.regWrite = 1'b1;
				ctl.ctrl.zeroExtend = 1'b1;
			end
			opJ:
				ctl.ctrl.jump = 1'b1;
			opJr:
			begin
				ctl.ctrl.jump = 1'b1;
				ctl.ctrl.aluSrc = 1'b1; // Target from rs
			end
			opJal:
			begin
				ctl.ctrl.jump = 1'b1;
				ctl.ctrl.regWrite = 1'b1;
			end
			opJalr:
			begin
				ctl.ctrl.jump = 1'b1;
				ctl.ctrl.aluSrc = 1'b1;
				ctl.ctrl.regWrite = 1'b1;
			end
			default:
				ctl.ctrl.err = 1'b1;
		endcase
	end

	errNoWrite: assert final (!(ctl.ctrl.err && ctl.ctrl.regWrite));

endmodule

`default_nettype wire

/* src/regFile.sv */
`default_nettype none
`timescale 1ns/1ns

module regFile (
	input logic clk,
	input logic [wiscPkg::regAddrWidth-1:0] rdAddrA,
	input logic [wiscPkg::regAddrWidth-1:0] rdAddrB,
	output logic [wiscPkg::dataWidth-1:0] rdDataA,
	output logic [wiscPkg::dataWidth-1:0] rdDataB,
	input logic wrEn,
	input logic [wiscPkg::regAddrWidth-1:0] wrAddr,
	input logic [wiscPkg::dataWidth-1:0] wrData
);
	import wiscPkg::*;

	logic [dataWidth-1:0] regs [2**regAddrWidth];

	// No bypass, a write shows up next cycle
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

	always_ff @(posedge clk)
	begin
		if (wrEn)
			regs[wrAddr] <= wrData;
	end

endmodule

`default_nettype wire

/* src/aluUnit.sv */
`default_nettype none
`timescale 1ns/1ns

module aluUnit (
	input wiscPkg::aluOpT op,
	input logic [wiscPkg::dataWidth-1:0] a,
	input logic [wiscPkg::dataWidth-1:0] b,
	output logic [wiscPkg::dataWidth-1:0] y
);
	import wiscPkg::*;

	logic [3:0] sh;
	logic [dataWidth:0] sum;
	logic [dataWidth-1:0] rev;

	assign sh = b[3:0];
	assign sum = {1'b0, a} + {1'b0, b};

	always_comb
	begin
		for (int i = 0; i < dataWidth; i++)
			rev[i] = a[dataWidth-1-i];
	end

	always_comb
	begin
		case (op)
			aluAdd: y = sum[dataWidth-1:0];
			aluSub: y = b - a;
			aluXor: y = a ^ b;
			aluAndn: y = a & ~b;
			aluRol: y = (a << sh) | (a >> (dataWidth - sh)); // sh of 0 leaves a
			aluSll: y = a << sh;
			aluRor: y = (a >> sh) | (a << (dataWidth - sh));
			aluSrl: y = a >> sh;
			aluSeq: y = {{(dataWidth-1){1'b0}}, a == b};
			aluSlt: y = {{(dataWidth-1){1'b0}}, $signed(a) < $signed(b)};
			aluSle: y = {{(dataWidth-1){1'b0}}, $signed(a) <= $signed(b)};
			aluSco: y = {{(dataWidth-1){1'b0}}, sum[dataWidth]};
			aluBtr: y = rev;
			aluSlbi: y = {a[7:0], b[7:0]};
			default: y = b; // LBI and passB
		endcase
	end

endmodule

`default_nettype wire

/* src/nextPcUnit.sv */
`default_nettype none
`timescale 1ns/1ns

module nextPcUnit (
	input logic clk,
	input logic rstN,
	input logic run,
	ctrlIf.dp ctl,
	input logic [1:0] brCond,
	input logic [wiscPkg::dataWidth-1:0] rsVal,
	input logic [wiscPkg::dataWidth-1:0] immVal,
	input logic [10:0] disp,
	output logic [wiscPkg::dataWidth-1:0] pc,
	output logic [wiscPkg::dataWidth-1:0] pcPlus2,
	output logic halted,
	output logic err
);
	import wiscPkg::*;

	logic taken;
	logic stop;
	logic [dataWidth-1:0] dispExt;
	logic [dataWidth-1:0] nextPc;

	assign pcPlus2 = pc + 16'd2;
	assign dispExt = {{(dataWidth-11){disp[10]}}, disp};
	assign stop = ctl.ctrl.halt || ctl.ctrl.err;

	always_comb
	begin
		case (brCond) // Low opcode bits
			2'b00: taken = (rsVal == '0);
			2'b01: taken = (rsVal != '0);
			2'b10: taken = rsVal[dataWidth-1];
			default: taken = !rsVal[dataWidth-1];
		endcase
	end

	always_comb
	begin
		if (ctl.ctrl.jump)
			nextPc = ctl.ctrl.aluSrc ? rsVal + immVal : pcPlus2 + dispExt;
		else if (ctl.ctrl.branch && taken)
			nextPc = pcPlus2 + immVal;
		else
			nextPc = pcPlus2;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			pc <= '0;
			halted <= 1'b0;
			err <= 1'b0;
		end
		else if (run && !halted)
		begin
			if (stop)
			begin
				halted <= 1'b1; // PC stays on the stopping instruction
				err <= ctl.ctrl.err;
			end
			else
				pc <= nextPc;
		end
	end

	pcEven: assert property (@(posedge clk) disable iff (!rstN) !pc[0]);

endmodule

`default_nettype wire

/* src/memBlock.sv */
`default_nettype none
`timescale 1ns/1ns

module memBlock #(
	parameter int depth = 256
) (
	input logic clk,
	input logic [wiscPkg::dataWidth-1:0] rdAddr,
	output logic [wiscPkg::dataWidth-1:0] rdData,
	input logic wrEn,
	input logic [wiscPkg::dataWidth-1:0] wrAddr,
	input logic [wiscPkg::dataWidth-1:0] wrData
);
	import wiscPkg::*;

	localparam int idxWidth = $clog2(depth);

	logic [dataWidth-1:0] mem [depth];

	// Byte address, word index
	assign rdData = mem[rdAddr[idxWidth:1]];

	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrAddr[idxWidth:1]] <= wrData;
	end

	wrInRange: assert property (@(posedge clk) wrEn |-> (wrAddr[dataWidth-1:1] < depth));

endmodule

`default_nettype wire

/* src/wiscCore.sv */
`default_nettype none
`timescale 1ns/1ns

module wiscCore #(
	parameter int imemDepth = 256,
	parameter int dmemDepth = 256
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic progWe,
	input logic [wiscPkg::dataWidth-1:0] progAddr,
	input logic [wiscPkg::dataWidth-1:0] progData,
	output logic halted,
	output logic err,
	output logic retire,
	output logic [wiscPkg::dataWidth-1:0] pcOut,
	output logic wbEn,
	output logic [wiscPkg::regAddrWidth-1:0] wbReg,
	output logic [wiscPkg::dataWidth-1:0] wbData
);
	import wiscPkg::*;

	logic [dataWidth-1:0] instr;
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] pcPlus2;
	logic [dataWidth-1:0] rsVal;
	logic [dataWidth-1:0] rtVal;
	logic [dataWidth-1:0] immVal;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluY;
	logic [dataWidth-1:0] memData;
	logic [regAddrWidth-1:0] wrReg;
	logic [dataWidth-1:0] wrData;
	logic advance;
	logic regWe;
	logic memWe;

	ctrlIf ctl ();

	memBlock #(.depth(imemDepth)) i_imem (
		.clk(clk),
		.rdAddr(pc),
		.rdData(instr),
		.wrEn(progWe),
		.wrAddr(progAddr),
		.wrData(progData)
	);

	ctrlDecoder i_ctrlDecoder (
		.opcode(opcodeT'(instr[15:11])),
		.func(instr[1:0]),
		.ctl(ctl)
	);

	regFile i_regFile (
		.clk(clk),
		.rdAddrA(instr[10:8]),
		.rdAddrB(instr[7:5]), // rt, or the store source
		.rdDataA(rsVal),
		.rdDataB(rtVal),
		.wrEn(regWe),
		.wrAddr(wrReg),
		.wrData(wrData)
	);

	always_comb
	begin
		if (ctl.ctrl.i1Fmt)
			immVal = ctl.ctrl.zeroExtend ? {11'b0, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
		else
			immVal = ctl.ctrl.zeroExtend ? {8'b0, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
	end

	assign aluB = ctl.ctrl.aluSrc ? immVal : rtVal;

	aluUnit i_aluUnit (
		.op(ctl.ctrl.aluOp),
		.a(rsVal),
		.b(aluB),
		.y(aluY)
	);

	nextPcUnit i_nextPcUnit (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.ctl(ctl),
		.brCond(instr[12:11]),
		.rsVal(rsVal),
		.immVal(immVal),
		.disp(instr[10:0]),
		.pc(pc),
		.pcPlus2(pcPlus2),
		.halted(halted),
		.err(err)
	);

	memBlock #(.depth(dmemDepth)) i_dmem (
		.clk(clk),
		.rdAddr(aluY),
		.rdData(memData),
		.wrEn(memWe),
		.wrAddr(aluY),
		.wrData(rtVal)
	);

	always_comb
	begin
		if (ctl.ctrl.regDst)
			wrReg = instr[4:2];
		else if (ctl.ctrl.i1Fmt && !ctl.ctrl.memWrite)
			wrReg = instr[7:5];
		else if (ctl.ctrl.jump && ctl.ctrl.regWrite)
			wrReg = 3'd7; // Link register
		else
			wrReg = instr[10:8]; // LBI, SLBI, STU
	end

	always_comb
	begin
		if (ctl.ctrl.jump)
			wrData = pcPlus2;
		else if (ctl.ctrl.memToReg && ctl.ctrl.memRead)
			wrData = memData;
		else
			wrData = aluY;
	end

	assign advance = run && !halted;
	assign regWe = advance && ctl.ctrl.regWrite;
	assign memWe = advance && ctl.ctrl.memWrite;

	assign retire = advance;
	assign pcOut = pc;
	assign wbEn = regWe;
	assign wbReg = wrReg;
	assign wbData = wrData;

endmodule

`default_nettype wire

/* verif/tbClock.sv */
`default_nettype none
`timescale 1ns/1ns

module tbClock #(
	parameter int halfPeriod = 5
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#halfPeriod clk = ~clk; // 10 ns period
	end

endmodule

`default_nettype wire

/* verif/isaModel.svh */
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Data memory lives across programs, like the DUT's
logic [15:0] mReg [8];
logic [15:0] mMem [256];
bit mValid [256];
logic [15:0] prog [48];
int progLen;
logic [35:0] expQ [$]; // {pc, wbEn, wbReg, wbData}

function automatic logic [15:0] rotl(input logic [15:0] v, input int s);
	logic [31:0] d;
	d = {v, v} << s;
	return d[31:16];
endfunction

function automatic logic [15:0] rotr(input logic [15:0] v, input int s);
	logic [31:0] d;
	d = {v, v} >> s;
	return d[15:0];
endfunction

function automatic logic [15:0] reverse16(input logic [15:0] v);
	logic [15:0] r;
	for (int k = 0; k < 16; k++)
		r[k] = v[15-k];
	return r;
endfunction

// Runs one instruction, logs its retire, returns the next index
function automatic int execInstr(input int idx);
	logic [15:0] ins;
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] val;
	logic [15:0] addr;
	logic [15:0] imm5s;
	logic [15:0] imm5z;
	logic [15:0] imm8s;
	logic [15:0] pc2;
	logic [16:0] wide;
	logic [2:0] wr;
	logic en;
	int nxt;
	ins = prog[idx];
	a = mReg[ins[10:8]];
	b = mReg[ins[7:5]];
	imm5s = {{11{ins[4]}}, ins[4:0]};
	imm5z = {11'b0, ins[4:0]};
	imm8s = {{8{ins[7]}}, ins[7:0]};
	addr = a + imm5s;
	pc2 = 16'(2 * idx + 2);
	en = 1'b0;
	wr = ins[7:5];
	val = '0;
	nxt = idx + 1;
	case (opcodeT'(ins[15:11]))
		opAddi: {en, val} = {1'b1, a + imm5s};
		opSubi: {en, val} = {1'b1, imm5s - a};
		opXori: {en, val} = {1'b1, a ^ imm5z};
		opAndni: {en, val} = {1'b1, a & ~imm5z};
		opRoli: {en, val} = {1'b1, rotl(a, ins[3:0])};
		opSlli: {en, val} = {1'b1, a << ins[3:0]};
		opRori: {en, val} = {1'b1, rotr(a, ins[3:0])};
		opSrli: {en, val} = {1'b1, a >> ins[3:0]};
		opSt:
		begin
			mMem[addr[8:1]] = b;
			mValid[addr[8:1]] = 1'b1;
		end
		opLd: {en, val} = {1'b1, mMem[addr[8:1]]};
		opStu:
		begin
			mMem[addr[8:1]] = b;
			mValid[addr[8:1]] = 1'b1;
			{en, wr, val} = {1'b1, ins[10:8], addr}; // Base register takes the address
		end
		opLbi: {en, wr, val} = {1'b1, ins[10:8], imm8s};
		opSlbi: {en, wr, val} = {1'b1, ins[10:8], a[7:0], ins[7:0]};
		opBtr: {en, wr, val} = {1'b1, ins[4:2], reverse16(a)};
		opArithR:
		begin
			{en, wr} = {1'b1, ins[4:2]};
			case (ins[1:0])
				2'b00: val = a + b;
				2'b01: val = b - a;
				2'b10: val = a ^ b;
				default: val = a & ~b;
			endcase
		end
		opShiftR:
		begin
			{en, wr} = {1'b1, ins[4:2]};
			case (ins[1:0])
				2'b00: val = rotl(a, b[3:0]);
				2'b01: val = a << b[3:0];
				2'b10: val = rotr(a, b[3:0]);
				default: val = a >> b[3:0];
			endcase
		end
		opSeq: {en, wr, val} = {1'b1, ins[4:2], 15'b0, a == b};
		opSlt: {en, wr, val} = {1'b1, ins[4:2], 15'b0, $signed(a) < $signed(b)};
		opSle: {en, wr, val} = {1'b1, ins[4:2], 15'b0, $signed(a) <= $signed(b)};
		opSco:
		begin
			wide = {1'b0, a} + {1'b0, b};
			{en, wr, val} = {1'b1, ins[4:2], 15'b0, wide[16]};
		end
		opBeqz: nxt = (a == 0) ? int'(16'(pc2 + imm8s) >> 1) : nxt;
		opBnez: nxt = (a != 0) ? int'(16'(pc2 + imm8s) >> 1) : nxt;
		opBltz: nxt = a[15] ? int'(16'(pc2 + imm8s) >> 1) : nxt;
		opBgez: nxt = !a[15] ? int'(16'(pc2 + imm8s) >> 1) : nxt;
		opJ: nxt = int'(16'(pc2 + {{5{ins[10]}}, ins[10:0]}) >> 1);
		opJal:
		begin
			nxt = int'(16'(pc2 + {{5{ins[10]}}, ins[10:0]}) >> 1);
			{en, wr, val} = {1'b1, 3'd7, pc2};
		end
		opJr: nxt = int'(16'(a + imm8s) >> 1);
		opJalr:
		begin
			nxt = int'(16'(a + imm8s) >> 1); // Old rs, before the link write
			{en, wr, val} = {1'b1, 3'd7, pc2};
		end
		default:
		begin
		end
	endcase
	if (en)
		mReg[wr] = val;
	expQ.push_back({16'(2 * idx), en, wr, val});
	return nxt;
endfunction

`endif

/* verif/wiscCoreTb.sv */
`default_nettype none
`timescale 1ns/1ns

module wiscCoreTb;
	import wiscPkg::*;

	localparam int numTests = 16;
	localparam int maxLen = 48;
	localparam int cycleLimit = numTests * (maxLen + maxLen + 8);

	logic clk;
	logic rstN;
	logic run;
	logic progWe;
	logic [15:0] progAddr;
	logic [15:0] progData;
	logic halted;
	logic err;
	logic retire;
	logic [15:0] pcOut;
	logic wbEn;
	logic [2:0] wbReg;
	logic [15:0] wbData;

	logic [31:0] lfsr;
	int cycles;
	int testErrs;
	int totalErrs;
	int failedTests;
	int checks;
	string testName;

	tbClock i_tbClock (.clk(clk));

	wiscCore i_wiscCore (
		.clk(clk),
		.rstN(rstN),
		.run(run),
		.progWe(progWe),
		.progAddr(progAddr),
		.progData(progData),
		.halted(halted),
		.err(err),
		.retire(retire),
		.pcOut(pcOut),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	function automatic logic [15:0] randBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			lfsr = galoisStep(lfsr); // One step per bit
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int randBelow(input int m);
		return int'(randBits(8)) % m;
	endfunction

	`include "isaModel.svh"

	function automatic logic [15:0] genImm();
		int r;
		logic [4:0] op;
		r = randBelow(11);
		op = (r < 4) ? 5'(int'(opAddi) + r) : 5'(int'(opRoli) + r - 4);
		if (r < 8)
			return {op, 11'(randBits(11))};
		else if (r == 8)
			return {opLbi, 11'(randBits(11))};
		else if (r == 9)
			return {opSlbi, 11'(randBits(11))};
		return {5'(randBelow(3) + 1), 11'(randBits(11))}; // NOP, SIIC, RTI
	endfunction

	task automatic genLive(input int kind, input int i, input int last, output int used);
		int r;
		int k;
		int w;
		int start;
		logic [2:0] rs;
		logic [4:0] imm5;
		logic [15:0] base;
		used = 1;
		rs = randBits(3);
		r = randBelow(4);
		if (kind == 0 || r == 0)
			prog[i] = genImm();
		else if (kind == 1)
			prog[i] = {5'(int'(opBtr) + randBelow(7)), 11'(randBits(11))};
		else if (kind == 2 && i + 1 < last)
		begin
			used = 2;
			r = randBelow(3);
			imm5 = randBits(5);
			base = 16'(16 + randBelow(96)); // Addresses stay in words 0 to 63
			if (r == 1)
			begin
				start = randBelow(64);
				w = -1;
				for (int j = 0; j < 64 && w < 0; j++)
					if (mValid[(start + j) % 64])
						w = (start + j) % 64;
				if (w < 0)
					r = 0; // Nothing stored yet so store instead
				else
				begin
					imm5 = randBits(4);
					base = 16'(2 * w) - {11'b0, imm5};
				end
			end
			prog[i] = {opLbi, rs, base[7:0]};
			prog[i+1] = {(r == 0) ? opSt : (r == 1) ? opLd : opStu, rs, 3'(randBits(3)), imm5};
		end
		else if (kind == 3)
		begin
			r = randBelow(8);
			k = randBelow(last - i); // Forward only and never past HALT
			if (r < 4)
				prog[i] = {5'(int'(opBeqz) + r), rs, 8'(2 * k)};
			else if (r < 6)
				prog[i] = {(r == 4) ? opJ : opJal, 11'(2 * k)};
			else if (i + 1 >= last)
				prog[i] = genImm();
			else
			begin
				used = 2;
				k = randBelow(last - i - 1);
				w = 2 * randBelow(4);
				prog[i] = {opLbi, rs, 8'(2 * (i + 2 + k) - w)};
				prog[i+1] = {(r == 6) ? opJr : opJalr, rs, 8'(w)};
			end
		end
		else
			prog[i] = genImm();
	endtask

	task automatic buildProgram(input int kind);
		int n;
		int i;
		int pc;
		int used;
		n = 24 + randBelow(25);
		progLen = n;
		expQ.delete();
		pc = 0;
		i = 0;
		while (i < n - 1)
		begin
			used = 1;
			if (i < 8)
				prog[i] = {opLbi, 3'(i), 8'(randBits(8))};
			else if (pc != i)
				prog[i] = genImm(); // Skipped by a branch
			else
				genLive(kind, i, n - 1, used);
			for (int j = 0; j < used; j++)
				if (pc == i + j)
					pc = execInstr(i + j);
			i += used;
		end
		prog[n-1] = {opHalt, 11'b0};
		void'(execInstr(n - 1));
	endtask

	task automatic checkEq(input string what, input logic [15:0] expVal,
		input logic [15:0] actVal);
		checks++;
		if (expVal !== actVal)
		begin
			testErrs++;
			$display("Fail %s %s: expected %h, actual %h", testName, what, expVal, actVal);
		end
	endtask

	task automatic resetCore();
		@(negedge clk);
		rstN = 1'b0;
		run = 1'b0;
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		checkEq("halted after reset", 0, halted);
		checkEq("err after reset", 0, err);
		checkEq("retire after reset", 0, retire);
	endtask

	task automatic loadProgram();
		for (int k = 0; k < progLen; k++)
		begin
			@(negedge clk);
			progWe = 1'b1;
			progAddr = 16'(2 * k);
			progData = prog[k];
		end
		@(negedge clk);
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		run = 1'b1;
	endtask

	task automatic runProgram();
		logic [35:0] rec;
		bit done;
		done = 1'b0;
		while (!done)
		begin
			@(posedge clk);
			if (halted)
				done = 1'b1;
			else if (expQ.size() == 0)
			begin
				testErrs++;
				$display("Test %s retired more instructions than the program runs", testName);
			end
			else
			begin
				rec = expQ.pop_front();
				checkEq("retire", 1, retire);
				checkEq("pcOut", rec[35:20], pcOut);
				checkEq("wbEn", rec[19], wbEn);
				if (rec[19])
				begin
					checkEq("wbReg", rec[18:16], wbReg);
					checkEq("wbData", rec[15:0], wbData);
				end
			end
		end
		checkEq("missing retires", 0, expQ.size());
		checkEq("err at halt", 0, err); // All 32 opcodes decode, so err stays low
		checkEq("retire while halted", 0, retire);
		@(posedge clk);
		checkEq("halted stays", 1, halted);
		checkEq("retire stays low", 0, retire);
		@(negedge clk);
		run = 1'b0;
	endtask

	function automatic string kindName(input int kind);
		case (kind)
			0: return "imm";
			1: return "rfmt";
			2: return "mem";
			default: return "branch";
		endcase
	endfunction

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("Timeout: the run did not end within %0d cycles", cycleLimit);
			$display("Regression failed");
			$finish;
		end
	end

	initial
	begin
		rstN = 1'b0;
		run = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		lfsr = 32'd97422;
		cycles = 0;
		totalErrs = 0;
		failedTests = 0;
		checks = 0;
		for (int t = 0; t < numTests; t++)
		begin
			testName = $sformatf("%s_%0d", kindName(t % 4), t);
			testErrs = 0;
			buildProgram(t % 4);
			resetCore();
			loadProgram();
			runProgram();
			$display("Test %s done with %0d mismatches", testName, testErrs);
			totalErrs += testErrs;
			if (testErrs != 0)
				failedTests++;
		end
		$display("Tests %0d, failing %0d, checks %0d, mismatches %0d",
			numTests, failedTests, checks, totalErrs);
		if (totalErrs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+verif
src/wiscPkg.sv
src/ctrlIf.sv
src/ctrlDecoder.sv
src/regFile.sv
src/aluUnit.sv
src/nextPcUnit.sv
src/memBlock.sv
src/wiscCore.sv
verif/tbClock.sv
verif/wiscCoreTb.sv

/* Bender.yml */
package:
  name: wiscCore

sources:
  - src/wiscPkg.sv
  - src/ctrlIf.sv
  - src/ctrlDecoder.sv
  - src/regFile.sv
  - src/aluUnit.sv
  - src/nextPcUnit.sv
  - src/memBlock.sv
  - src/wiscCore.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tbClock.sv
      - verif/wiscCoreTb.sv
